// File: design/egress_pkg.sv
package egress_pkg;

    ////////////////////
    // word and field widths
    localparam int WORD_W = 64;
    localparam int PRI_W  = 2;
    localparam int CRC_W  = 32;
    localparam int LEN_W  = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [PRI_W-1:0]  pri_t;   // higher value wins
    typedef logic [CRC_W-1:0]  crc_t;
    typedef logic [LEN_W-1:0]  len_t;   // payload words, 1..255

    ////////////////////
    // header word layout, bits above 41 unused
    localparam int HDR_PRI_LSB = 0;
    localparam int HDR_PRI_MSB = 1;
    localparam int HDR_CRC_LSB = 2;
    localparam int HDR_CRC_MSB = 33;
    localparam int HDR_LEN_LSB = 34;
    localparam int HDR_LEN_MSB = 41;

    // reflected crc-32, word fed lsb first, no final xor
    localparam crc_t CRC_POLY = 32'hedb8_8320;
    localparam crc_t CRC_INIT = 32'hffff_ffff;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ARB,
        S_HDR_WAIT,
        S_STREAM,
        S_DRAIN
    } sched_state_t;

endpackage

// File: design/frame_bus_if.sv
`timescale 1ns/10ps

interface frame_bus_if;
    import egress_pkg::*;

    word_t data;
    logic  sop;
    logic  eop;
    logic  err;     // crc mismatch, only with eop
    logic  vld;
    logic  credit;  // one pulse per word drained

    modport sender (
        output data, sop, eop, err, vld,
        input  credit
    );

    modport receiver (
        input  data, sop, eop, err, vld,
        output credit
    );

endinterface

// File: design/queue_bank.sv
`timescale 1ns/10ps

module queue_bank #(
    parameter int  NUM_PORTS   = 4,
    parameter int  QUEUE_DEPTH = 64,
    localparam int PORT_W      = $clog2(NUM_PORTS)
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [NUM_PORTS-1:0]                    in_valid,
    input  logic [NUM_PORTS-1:0]                    in_last,
    input  logic [NUM_PORTS*egress_pkg::WORD_W-1:0] in_data,
    output logic [NUM_PORTS-1:0]                    in_full,
    output logic [NUM_PORTS-1:0]                    frame_avail,
    output logic [NUM_PORTS*egress_pkg::PRI_W-1:0]  head_pri,
    input  logic                                    rd_en,
    input  logic [PORT_W-1:0]                       rd_sel,
    output egress_pkg::word_t                       rd_data
);
    import egress_pkg::*;

    localparam int AW = $clog2(QUEUE_DEPTH);
    localparam int CW = AW + 1;

    word_t                mem     [NUM_PORTS][QUEUE_DEPTH];
    logic [AW-1:0]        wr_ptr  [NUM_PORTS];
    logic [AW-1:0]        rd_ptr  [NUM_PORTS];
    logic [CW-1:0]        used    [NUM_PORTS];  // words held
    logic [CW-1:0]        frames  [NUM_PORTS];  // complete frames held
    len_t                 rd_left [NUM_PORTS];  // 0 means next read is a header
    logic [NUM_PORTS-1:0] wr_ok;
    logic [NUM_PORTS-1:0] rd_hit;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_full[p]     = (used[p] == CW'(QUEUE_DEPTH));
            frame_avail[p] = (frames[p] != '0);
            wr_ok[p]       = in_valid[p] && !in_full[p];  // write into full queue dropped
            rd_hit[p]      = rd_en && (rd_sel == PORT_W'(p));
            // word at read pointer, a header whenever a frame is waiting
            head_pri[p*PRI_W +: PRI_W] = mem[p][rd_ptr[p]][HDR_PRI_MSB:HDR_PRI_LSB];
        end
    end

    ////////////////////
    // storage
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr_ok[p]) begin
                mem[p][wr_ptr[p]] <= in_data[p*WORD_W +: WORD_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_sel][rd_ptr[rd_sel]];
        end
    end

    ////////////////////
    // pointers and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_ptr[p]  <= '0;
                rd_ptr[p]  <= '0;
                used[p]    <= '0;
                frames[p]  <= '0;
                rd_left[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (wr_ok[p]) begin
                    wr_ptr[p] <= next_ptr(wr_ptr[p]);
                end
                if (rd_hit[p]) begin
                    rd_ptr[p] <= next_ptr(rd_ptr[p]);
                    if (rd_left[p] == '0) begin
                        rd_left[p] <= mem[p][rd_ptr[p]][HDR_LEN_MSB:HDR_LEN_LSB];
                    end else begin
                        rd_left[p] <= rd_left[p] - 1'b1;
                    end
                end
                used[p]   <= used[p] + CW'(wr_ok[p]) - CW'(rd_hit[p]);
                // up on in_last, down when the header goes out
                frames[p] <= frames[p] + CW'(wr_ok[p] && in_last[p])
                                       - CW'(rd_hit[p] && (rd_left[p] == '0));
            end
        end
    end

endmodule

// File: design/priority_arbiter.sv
`timescale 1ns/10ps

module priority_arbiter #(
    parameter int  NUM_PORTS = 4,
    localparam int PORT_W    = $clog2(NUM_PORTS)
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [NUM_PORTS-1:0]                   req,
    input  logic [NUM_PORTS*egress_pkg::PRI_W-1:0] pri,
    input  logic                                   arb_en,
    output logic [PORT_W-1:0]                      grant,
    output logic                                   grant_vld
);
    import egress_pkg::*;

    logic [PORT_W-1:0] rr_ptr;   // first port looked at on a tie
    pri_t              top_pri;

    // best priority among requesters
    always_comb begin
        top_pri = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (req[p] && (pri[p*PRI_W +: PRI_W] > top_pri)) begin
                top_pri = pri[p*PRI_W +: PRI_W];
            end
        end
    end

    // scan from rr_ptr, take the first match at top_pri
    always_comb begin
        int idx;
        grant     = '0;
        grant_vld = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;  // wrap
            end
            if (!grant_vld && req[idx] && (pri[idx*PRI_W +: PRI_W] == top_pri)) begin
                grant     = PORT_W'(idx);
                grant_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (arb_en && grant_vld) begin
            rr_ptr <= (grant == PORT_W'(NUM_PORTS - 1)) ? '0 : grant + 1'b1;
        end
    end

endmodule

// File: design/crc32_calc.sv
`timescale 1ns/10ps

module crc32_calc (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,
    input  logic              enable,
    input  egress_pkg::word_t data,
    output egress_pkg::crc_t  crc,
    output egress_pkg::crc_t  crc_next
);
    import egress_pkg::*;

    // 64 serial steps unrolled, bit 0 of the word first
    always_comb begin
        crc_t c;
        c = crc;
        for (int i = 0; i < WORD_W; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        crc_next = c;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= CRC_INIT;
        end else if (clear) begin
            crc <= CRC_INIT;   // start of a new frame
        end else if (enable) begin
            crc <= crc_next;
        end
    end

endmodule

// File: design/frame_scheduler.sv
`timescale 1ns/10ps

module frame_scheduler #(
    parameter int  NUM_PORTS  = 4,
    parameter int  FIFO_DEPTH = 8,
    localparam int PORT_W     = $clog2(NUM_PORTS)
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [NUM_PORTS-1:0]                   frame_avail,
    input  logic [NUM_PORTS*egress_pkg::PRI_W-1:0] head_pri,
    output logic                                   rd_en,
    output logic [PORT_W-1:0]                      rd_sel,
    input  egress_pkg::word_t                      rd_data,
    frame_bus_if.sender                            bus
);
    import egress_pkg::*;

    localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

    sched_state_t      state;
    logic [PORT_W-1:0] grant;
    logic              grant_vld;
    logic [PORT_W-1:0] cur_port;    // port being served
    len_t              frame_len;
    crc_t              hdr_crc;
    len_t              issued;      // payload reads sent
    len_t              landed;      // payload words on the bus
    logic [CRD_W-1:0]  credits;
    logic              rd_pend;     // payload read from last cycle lands now
    logic              pay_rd;
    logic              last_rd;
    crc_t              crc_next;

    priority_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) i_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (frame_avail),
        .pri       (head_pri),
        .arb_en    (state == S_ARB),
        .grant     (grant),
        .grant_vld (grant_vld)
    );

    crc32_calc i_crc (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (state == S_HDR_WAIT),
        .enable   (bus.vld),
        .data     (rd_data),
        .crc      (),
        .crc_next (crc_next)
    );

    ////////////////////
    // bank reads
    always_comb begin
        rd_en  = 1'b0;
        rd_sel = cur_port;
        case (state)
            S_ARB: begin
                rd_en  = grant_vld;  // header, same cycle as the grant latch
                rd_sel = grant;
            end
            S_STREAM: begin
                // a credit coming back this cycle counts too
                rd_en = (credits != '0) || bus.credit;
            end
            default: begin
                rd_en = 1'b0;
            end
        endcase
    end

    assign pay_rd  = rd_en && (state == S_STREAM);
    assign last_rd = (issued == frame_len - 1'b1);

    ////////////////////
    // bus side, word lands one cycle after its read
    assign bus.vld  = rd_pend;
    assign bus.data = rd_data;
    assign bus.sop  = rd_pend && (landed == '0);
    assign bus.eop  = rd_pend && (landed == frame_len - 1'b1);
    assign bus.err  = bus.eop && (crc_next != hdr_crc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cur_port  <= '0;
            frame_len <= '0;
            issued    <= '0;
            landed    <= '0;
            credits   <= CRD_W'(FIFO_DEPTH);
            rd_pend   <= 1'b0;
        end else begin
            rd_pend <= pay_rd;
            // credit taken at the read, the word follows next cycle
            credits <= credits - CRD_W'(pay_rd) + CRD_W'(bus.credit);
            if (pay_rd) begin
                issued <= issued + 1'b1;
            end
            if (bus.vld) begin
                landed <= landed + 1'b1;
            end

            case (state)
                S_IDLE: begin
                    if (|frame_avail) begin
                        state <= S_ARB;
                    end
                end
                S_ARB: begin
                    if (grant_vld) begin
                        cur_port <= grant;
                        state    <= S_HDR_WAIT;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_HDR_WAIT: begin
                    frame_len <= rd_data[HDR_LEN_MSB:HDR_LEN_LSB];
                    issued    <= '0;
                    landed    <= '0;
                    state     <= S_STREAM;
                end
                S_STREAM: begin
                    if (pay_rd && last_rd) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (bus.eop) begin
                        state <= S_IDLE;   // last word is on the bus
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_HDR_WAIT) begin
            hdr_crc <= rd_data[HDR_CRC_MSB:HDR_CRC_LSB];
        end
    end

endmodule

// File: design/egress_fifo.sv
`timescale 1ns/10ps

module egress_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    frame_bus_if.receiver     bus,
    output egress_pkg::word_t out_data,
    output logic              out_sop,
    output logic              out_eop,
    output logic              out_err,
    output logic              out_valid,
    input  logic              out_ready
);
    import egress_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    word_t         data_mem [FIFO_DEPTH];
    logic [2:0]    flag_mem [FIFO_DEPTH];  // {err, eop, sop}
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;

    assign out_valid  = (count != '0);
    assign pop        = out_valid && out_ready;
    assign bus.credit = pop;                 // one credit back per word out
    assign out_data   = data_mem[rd_ptr];
    assign {out_err, out_eop, out_sop} = flag_mem[rd_ptr];

    // sender holds a credit for every write, no full check here
    always_ff @(posedge clk) begin
        if (bus.vld) begin
            data_mem[wr_ptr] <= bus.data;
            flag_mem[wr_ptr] <= {bus.err, bus.eop, bus.sop};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (bus.vld) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(bus.vld) - CW'(pop);
        end
    end

endmodule

// File: design/egress_top.sv
`timescale 1ns/10ps

module egress_top #(
    parameter int NUM_PORTS   = 4,
    parameter int QUEUE_DEPTH = 64,
    parameter int FIFO_DEPTH  = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [NUM_PORTS-1:0]                    in_valid,
    input  logic [NUM_PORTS-1:0]                    in_last,
    input  logic [NUM_PORTS*egress_pkg::WORD_W-1:0] in_data,
    output logic [NUM_PORTS-1:0]                    in_full,
    output egress_pkg::word_t                       out_data,
    output logic                                    out_sop,
    output logic                                    out_eop,
    output logic                                    out_err,
    output logic                                    out_valid,
    input  logic                                    out_ready
);
    import egress_pkg::*;

    localparam int PORT_W = $clog2(NUM_PORTS);

    ////////////////////
    // bank to scheduler
    logic [NUM_PORTS-1:0]       frame_avail;
    logic [NUM_PORTS*PRI_W-1:0] head_pri;
    logic                       rd_en;
    logic [PORT_W-1:0]          rd_sel;
    word_t                      rd_data;

    frame_bus_if frame_bus ();

    queue_bank #(
        .NUM_PORTS   (NUM_PORTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_last     (in_last),
        .in_data     (in_data),
        .in_full     (in_full),
        .frame_avail (frame_avail),
        .head_pri    (head_pri),
        .rd_en       (rd_en),
        .rd_sel      (rd_sel),
        .rd_data     (rd_data)
    );

    frame_scheduler #(
        .NUM_PORTS   (NUM_PORTS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) i_frame_scheduler (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_avail (frame_avail),
        .head_pri    (head_pri),
        .rd_en       (rd_en),
        .rd_sel      (rd_sel),
        .rd_data     (rd_data),
        .bus         (frame_bus.sender)
    );

    egress_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_egress_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (frame_bus.receiver),
        .out_data   (out_data),
        .out_sop    (out_sop),
        .out_eop    (out_eop),
        .out_err    (out_err),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

// File: bench/tb_egress.sv
`timescale 1ns/10ps

module tb_egress;
    import egress_pkg::*;

    localparam int NUM_PORTS   = 4;
    localparam int QUEUE_DEPTH = 64;
    localparam int FIFO_DEPTH  = 8;
    localparam int FULL_PORT   = 2;     // port used for the queue-full case
    localparam int EXP_MAX     = 1024;

    logic                        clk;
    logic                        rst_n;
    logic [NUM_PORTS-1:0]        in_valid;
    logic [NUM_PORTS-1:0]        in_last;
    logic [NUM_PORTS*WORD_W-1:0] in_data;
    logic [NUM_PORTS-1:0]        in_full;
    word_t                       out_data;
    logic                        out_sop;
    logic                        out_eop;
    logic                        out_err;
    logic                        out_valid;
    logic                        out_ready;

    // expected egress stream, filled in output order
    word_t      exp_data [EXP_MAX];
    logic [2:0] exp_flag [EXP_MAX];     // {err, eop, sop}
    int         exp_count;
    int         rx_count = 0;
    word_t      exp_head;
    logic [2:0] exp_head_flag;
    int         rr_ptr;                 // model of the arbiter pointer
    int         sent_words;
    logic       rand_ready;
    logic       fill_check;

    assign exp_head      = exp_data[rx_count];
    assign exp_head_flag = exp_flag[rx_count];

    egress_top #(
        .NUM_PORTS   (NUM_PORTS),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_data   (in_data),
        .in_full   (in_full),
        .out_data  (out_data),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .out_err   (out_err),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        out_ready <= rand_ready ? (($urandom % 3) != 0) : 1'b1;
        if (rst_n && out_valid && out_ready) begin
            rx_count <= rx_count + 1;   // one word accepted
        end
    end

    task automatic value_error(input string name, input word_t got, input word_t want);
        $display("error %s got 0x%h expected 0x%h", name, got, want);
        $display("Errors found");
        $fatal(1, "value mismatch");
    endtask

    task automatic plain_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "check failed");
    endtask

    ////////////////////
    // checks
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_data == exp_head)
        else value_error("out_data", $sampled(out_data), $sampled(exp_head));
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_sop == exp_head_flag[0])
        else value_error("out_sop", $sampled(out_sop), $sampled(exp_head_flag[0]));
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_eop == exp_head_flag[1])
        else value_error("out_eop", $sampled(out_eop), $sampled(exp_head_flag[1]));
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_err == exp_head_flag[2])
        else value_error("out_err", $sampled(out_err), $sampled(exp_head_flag[2]));
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> rx_count < exp_count)
        else plain_error("the DUT offered a word that belongs to no sent frame");
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
                                    && $stable({out_sop, out_eop, out_err}))
        else plain_error("the out ports changed while out_ready was low");
    assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !out_valid)
        else value_error("out_valid", $sampled(out_valid), 0);
    assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> in_full == '0)
        else value_error("in_full", $sampled(in_full), 0);
    assert property (@(posedge clk) disable iff (!rst_n)
        fill_check |=> in_full[FULL_PORT])
        else value_error("in_full", $sampled(in_full), 1 << FULL_PORT);
    assert property (@(posedge clk) disable iff (!rst_n)
        |in_full |-> ##[1:50] !(|in_full))
        else plain_error("in_full stayed high although the queue was being read");

    ////////////////////
    // frame model
    function automatic crc_t frame_crc(input word_t pay [$]);
        crc_t c;
        c = CRC_INIT;
        foreach (pay[w]) begin
            for (int k = 0; k < 8; k++) begin
                c = c ^ {24'h0, pay[w][8*k +: 8]};   // low byte first
                repeat (8) c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
            end
        end
        return c;
    endfunction

    function automatic int ring_dist(input int p);
        return (p - rr_ptr + NUM_PORTS) % NUM_PORTS;
    endfunction

    // header plus payload, payload also goes to the expected stream
    task automatic build_frame(input int len, input pri_t pr, input bit bad,
                               inout word_t words [$], inout bit lasts [$]);
        word_t pay [$];
        word_t hdr;
        crc_t  crc;
        for (int i = 0; i < len; i++) begin
            pay.push_back({$urandom, $urandom});
        end
        crc = frame_crc(pay);
        if (bad) begin
            crc = crc ^ (32'h1 << ($urandom % 32));
        end
        hdr = {$urandom, $urandom};     // unused upper bits stay random
        hdr[HDR_PRI_MSB:HDR_PRI_LSB] = pr;
        hdr[HDR_CRC_MSB:HDR_CRC_LSB] = crc;
        hdr[HDR_LEN_MSB:HDR_LEN_LSB] = len_t'(len);
        words.push_back(hdr);
        lasts.push_back(1'b0);
        foreach (pay[i]) begin
            words.push_back(pay[i]);
            lasts.push_back(i == len - 1);
            exp_data[exp_count] = pay[i];
            exp_flag[exp_count] = {bad && (i == len - 1), i == len - 1, i == 0};
            exp_count++;
        end
    endtask

    task automatic send_words(input int p, input word_t words [$], input bit lasts [$],
                              input bit mark);
        foreach (words[i]) begin
            @(posedge clk);
            in_valid[p]                 <= 1'b1;
            in_last[p]                  <= lasts[i];
            in_data[p*WORD_W +: WORD_W] <= words[i];
            fill_check                  <= mark && (i == words.size() - 1);
            sent_words++;
        end
        @(posedge clk);
        in_valid[p] <= 1'b0;
        in_last[p]  <= 1'b0;
        fill_check  <= 1'b0;
    endtask

    task automatic port_frame(input int p, input int len, input bit bad, input bit mark);
        word_t words [$];
        bit    lasts [$];
        build_frame(len, pri_t'($urandom), bad, words, lasts);
        rr_ptr = (p + 1) % NUM_PORTS;   // only this port asks
        send_words(p, words, lasts, mark);
    endtask

    // two ports finish their frames on the same cycles
    task automatic burst(input int a, input int b, input int nfr, input bit tie);
        int    port [2];
        int    len  [2];
        pri_t  pr   [2][2];
        int    nxt  [2];
        int    s;
        word_t words [2][$];
        bit    lasts [2][$];
        port = '{a, b};
        nxt  = '{0, 0};
        for (int k = 0; k < nfr; k++) begin
            len[k]   = 1 + $urandom % 12;
            // one level for the whole tie burst
            pr[0][k] = (tie && k > 0) ? pr[0][0] : pri_t'($urandom);
            pr[1][k] = tie ? pr[0][k] : pr[0][k] + pri_t'(1 + $urandom % 3);
        end
        repeat (2 * nfr) begin
            if (nxt[0] == nfr) begin
                s = 1;
            end else if (nxt[1] == nfr) begin
                s = 0;
            end else if (pr[0][nxt[0]] != pr[1][nxt[1]]) begin
                s = int'(pr[1][nxt[1]] > pr[0][nxt[0]]);
            end else begin
                s = int'(ring_dist(port[1]) < ring_dist(port[0]));  // tie, pointer order
            end
            build_frame(len[nxt[s]], pr[s][nxt[s]], 1'b0, words[s], lasts[s]);
            rr_ptr = (port[s] + 1) % NUM_PORTS;
            nxt[s]++;
        end
        fork
            send_words(a, words[0], lasts[0], 1'b0);
            send_words(b, words[1], lasts[1], 1'b0);
        join
    endtask

    task automatic wait_drained();
        while (rx_count != exp_count) begin
            @(posedge clk);
        end
    endtask

    ////////////////////
    // stimulus
    initial begin : stimulus
        void'($urandom(81));
        rst_n      = 1'b1;
        in_valid   = '0;
        in_last    = '0;
        in_data    = '0;
        out_ready  = 1'b1;
        rand_ready = 1'b0;
        fill_check = 1'b0;
        exp_count  = 0;
        sent_words = 0;
        rr_ptr     = 0;
        #1 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // single ports, odd ports lead with a bad crc
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_frame(p, (p == 0) ? 1 : 1 + $urandom % 12, p % 2, 1'b0);
            port_frame(p, 1 + $urandom % 12, 1'b0, 1'b0);
            wait_drained();
        end

        // priority pairs
        burst(0, 3, 1, 1'b0);
        wait_drained();
        burst(1, 2, 1, 1'b0);
        wait_drained();
        burst(2, 0, 1, 1'b0);
        wait_drained();
        burst(3, 1, 1, 1'b0);
        wait_drained();

        // equal priority, two frames per port
        burst(0, 2, 2, 1'b1);
        wait_drained();
        burst(1, 3, 2, 1'b1);
        wait_drained();
        burst(3, 0, 2, 1'b1);
        wait_drained();

        // back-pressure, one queue filled to the brim
        rand_ready <= 1'b1;
        port_frame(FULL_PORT, QUEUE_DEPTH - 1, 1'b0, 1'b1);
        port_frame(1, 20, 1'b1, 1'b0);
        wait_drained();
        burst(0, 1, 2, 1'b1);
        wait_drained();
        rand_ready <= 1'b0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        if (rx_count != exp_count || out_valid) begin
            $display("egress stream does not match the frames sent");
            $display("Errors found");
            $fatal(1, "stream mismatch");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 40 * sent_words + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, frames did not leave the DUT in time");
        $display("Errors found");
        $fatal(1, "timeout");
    end

endmodule

// File: verilog.f
design/egress_pkg.sv
design/frame_bus_if.sv
design/queue_bank.sv
design/priority_arbiter.sv
design/crc32_calc.sv
design/frame_scheduler.sv
design/egress_fifo.sv
design/egress_top.sv
bench/tb_egress.sv

// File: Bender.yml
package:
  name: egress_switch

sources:
  - design/egress_pkg.sv
  - design/frame_bus_if.sv
  - design/queue_bank.sv
  - design/priority_arbiter.sv
  - design/crc32_calc.sv
  - design/frame_scheduler.sv
  - design/egress_fifo.sv
  - design/egress_top.sv
  - target: test
    files:
      - bench/tb_egress.sv
